// ==== rtl/ioCtrlPkg.sv ====
// IO command controller shared types
package ioCtrlPkg;

    // Core register index width
    localparam int REG_IDX_W = 4;

    // Entries in each port queue
    localparam int FIFO_DEPTH = 8;

    // Bit 2 marks a store; bit 3 means send-now on a store and fetch on a load
    typedef enum logic [3:0] {
        LD_STALE_BYTE  = 4'b0000,
        LD_STALE_SBYTE = 4'b0001,
        LD_STALE_WORD  = 4'b0010,
        LD_BYTE        = 4'b1000,
        LD_SBYTE       = 4'b1001,
        LD_WORD        = 4'b1010,
        ST_BYTE        = 4'b0100,
        ST_WORD        = 4'b0110,
        ST_BYTE_SEND   = 4'b1100,
        ST_WORD_SEND   = 4'b1110
    } ioMinorOp;

    // Low two opcode bits
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'b00,
        SZ_SBYTE = 2'b01,
        SZ_WORD  = 2'b10
    } accessSize;

    typedef enum logic [1:0] {
        KIND_STALE_LOAD = 2'b00,
        KIND_LOAD       = 2'b01,
        KIND_STORE      = 2'b10
    } cmdKind;

endpackage

// ==== rtl/ioCmdIf.sv ====
// Decoded command link
`timescale 1ns/1ns

interface ioCmdIf #(
    parameter int PORT_BYTES = 4,
    parameter int DATA_W = 16
) ();

    localparam int SLOTS = (PORT_BYTES * 8) / DATA_W;
    localparam int SLOT_BITS = (SLOTS <= 2) ? 1 : $clog2(SLOTS);
    // Slot index plus byte lane
    localparam int ADDR_W = SLOT_BITS + 1;

    ioCtrlPkg::cmdKind kind;
    ioCtrlPkg::ioMinorOp op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [ioCtrlPkg::REG_IDX_W-1:0] dest;
    logic ack;
    logic req;

    modport sender(output kind, op, addr, data, dest, ack, input req);
    modport receiver(input kind, op, addr, data, dest, ack, output req);

endinterface

// ==== rtl/cmdDecode.sv ====
// Core command input stage
`timescale 1ns/1ns

module cmdDecode #(
    parameter int PORT_BYTES = 4,
    parameter int DATA_W = 16
) (
    input  logic                            sys_clk,
    input  logic                            rstN,
    input  logic                            cmdAck,
    input  ioCtrlPkg::ioMinorOp             minorOp,
    input  logic [DATA_W-1:0]               addrOffset,
    input  logic [DATA_W-1:0]               cmdData,
    input  logic [ioCtrlPkg::REG_IDX_W-1:0] destReg,
    output logic                            cmdReq,
    ioCmdIf.sender                          down
);

    localparam int SLOTS = (PORT_BYTES * 8) / DATA_W;
    localparam int SLOT_BITS = (SLOTS <= 2) ? 1 : $clog2(SLOTS);
    localparam int ADDR_W = SLOT_BITS + 1;

    logic take;
    ioCtrlPkg::cmdKind kindNext;

    // Open when empty or when the held entry leaves this cycle
    assign cmdReq = !down.ack || down.req;
    assign take = cmdAck && cmdReq;

    always_comb begin
        if (minorOp[2]) begin
            kindNext = ioCtrlPkg::KIND_STORE;
        end else if (minorOp[3]) begin
            kindNext = ioCtrlPkg::KIND_LOAD;
        end else begin
            kindNext = ioCtrlPkg::KIND_STALE_LOAD;
        end
    end

    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            down.ack <= 1'b0;
        end else if (take) begin
            down.ack <= 1'b1;
        end else if (down.req) begin
            down.ack <= 1'b0;
        end
    end

    // Held command fields
    always_ff @(posedge sys_clk) begin
        if (take) begin
            down.kind <= kindNext;
            down.op <= minorOp;
            down.addr <= addrOffset[ADDR_W-1:0];
            down.data <= cmdData;
            down.dest <= destReg;
        end
    end

endmodule

// ==== rtl/storePacker.sv ====
// Store merge buffer and port command issue
`timescale 1ns/1ns

module storePacker #(
    parameter int PORT_BYTES = 4,
    parameter int DATA_W = 16,
    localparam int PORT_W = PORT_BYTES * 8,
    localparam int SLOTS = PORT_W / DATA_W,
    localparam int SLOT_BITS = (SLOTS <= 2) ? 1 : $clog2(SLOTS),
    localparam int ADDR_W = SLOT_BITS + 1,
    localparam int CMD_W = 1 + ioCtrlPkg::REG_IDX_W + PORT_W
) (
    input  logic                            sys_clk,
    input  logic                            rstN,
    ioCmdIf.receiver                        up,
    output logic                            fifoAck,
    output logic [CMD_W-1:0]                fifoData,
    input  logic                            fifoReq,
    output logic                            staleAck,
    output ioCtrlPkg::ioMinorOp             staleOp,
    output logic [ADDR_W-1:0]               staleAddr,
    output logic [ioCtrlPkg::REG_IDX_W-1:0] staleDest,
    input  logic                            staleReq
);

    localparam int BYTES_PER_WORD = DATA_W / 8;

    logic [SLOTS-1:0][DATA_W-1:0] storeWord;
    logic [SLOTS-1:0][DATA_W-1:0] mergedWord;
    logic [SLOT_BITS-1:0] slot;
    logic byteLane;
    logic isWordStore;
    logic sendNow;
    logic cmdFree;
    logic staleFree;
    logic takeStore;
    logic takeLoad;
    logic takeStale;
    logic queueCmd;

    assign slot = up.addr[SLOT_BITS-1:0];
    // Narrow data words carry a single byte lane
    assign byteLane = (BYTES_PER_WORD > 1) ? up.addr[SLOT_BITS] : 1'b0;
    assign isWordStore = ioCtrlPkg::accessSize'(up.op[1:0]) == ioCtrlPkg::SZ_WORD;
    assign sendNow = up.op[3];

    always_comb begin
        mergedWord = storeWord;
        if (isWordStore) begin
            mergedWord[slot] = up.data;
        end else begin
            mergedWord[slot][8*byteLane +: 8] = up.data[7:0];
        end
    end

    assign cmdFree = !fifoAck || fifoReq;
    assign staleFree = !staleAck || staleReq;

    // Only the output a command needs has to be free
    always_comb begin
        case (up.kind)
            ioCtrlPkg::KIND_STORE: up.req = sendNow ? cmdFree : 1'b1;
            ioCtrlPkg::KIND_LOAD:  up.req = cmdFree;
            default:               up.req = staleFree;
        endcase
    end

    assign takeStore = up.ack && up.req && (up.kind == ioCtrlPkg::KIND_STORE);
    assign takeLoad = up.ack && up.req && (up.kind == ioCtrlPkg::KIND_LOAD);
    assign takeStale = up.ack && up.req && (up.kind == ioCtrlPkg::KIND_STALE_LOAD);
    assign queueCmd = (takeStore && sendNow) || takeLoad;

    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            storeWord <= '0;
            fifoAck <= 1'b0;
            staleAck <= 1'b0;
        end else begin
            if (takeStore) begin
                storeWord <= mergedWord;
            end
            if (queueCmd) begin
                fifoAck <= 1'b1;
            end else if (fifoReq) begin
                fifoAck <= 1'b0;
            end
            if (takeStale) begin
                staleAck <= 1'b1;
            end else if (staleReq) begin
                staleAck <= 1'b0;
            end
        end
    end

    // Send-store carries the merged word, fetch asks for a response
    always_ff @(posedge sys_clk) begin
        if (takeStore && sendNow) begin
            fifoData <= {1'b0, up.dest, mergedWord};
        end else if (takeLoad) begin
            fifoData <= {1'b1, up.dest, storeWord};
        end
        if (takeStale) begin
            staleOp <= up.op;
            staleAddr <= up.addr;
            staleDest <= up.dest;
        end
    end

endmodule

// ==== rtl/syncFifo.sv ====
// Handshake FIFO
`timescale 1ns/1ns

module syncFifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = ioCtrlPkg::FIFO_DEPTH
) (
    input  logic             sys_clk,
    input  logic             rstN,
    input  logic             inAck,
    input  logic [WIDTH-1:0] inData,
    output logic             inReq,
    output logic             outAck,
    output logic [WIDTH-1:0] outData,
    input  logic             outReq
);

    localparam int PTR_W = (DEPTH <= 2) ? 1 : $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic push;
    logic pop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign inReq = count != CNT_W'(DEPTH);
    assign outAck = count != '0;
    assign outData = mem[rdPtr];
    assign push = inAck && inReq;
    assign pop = outAck && outReq;

    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

endmodule

// ==== rtl/writebackStage.sv ====
// Load word and writeback arbitration
`timescale 1ns/1ns

module writebackStage #(
    parameter int PORT_BYTES = 4,
    parameter int DATA_W = 16,
    localparam int PORT_W = PORT_BYTES * 8,
    localparam int SLOTS = PORT_W / DATA_W,
    localparam int SLOT_BITS = (SLOTS <= 2) ? 1 : $clog2(SLOTS),
    localparam int ADDR_W = SLOT_BITS + 1,
    localparam int RSP_W = 1 + ioCtrlPkg::REG_IDX_W + PORT_W
) (
    input  logic                            sys_clk,
    input  logic                            rstN,
    input  logic                            rspAck,
    input  logic [RSP_W-1:0]                rspData,
    output logic                            rspReq,
    input  logic                            staleAck,
    input  ioCtrlPkg::ioMinorOp             staleOp,
    input  logic [ADDR_W-1:0]               staleAddr,
    input  logic [ioCtrlPkg::REG_IDX_W-1:0] staleDest,
    output logic                            staleReq,
    output logic                            wbAck,
    input  logic                            wbReq,
    output logic [ioCtrlPkg::REG_IDX_W-1:0] wbDestReg,
    output logic [DATA_W-1:0]               wbData
);

    localparam int BYTES_PER_WORD = DATA_W / 8;

    logic rspIsReg;
    logic [ioCtrlPkg::REG_IDX_W-1:0] rspDest;
    logic [PORT_W-1:0] rspWord;
    logic regWb;
    logic [SLOTS-1:0][DATA_W-1:0] loadWord;
    logic [DATA_W-1:0] slotWord;
    logic [7:0] slotByte;
    logic byteLane;
    logic [DATA_W-1:0] staleData;

    assign rspIsReg = rspData[RSP_W-1];
    assign rspDest = rspData[PORT_W +: ioCtrlPkg::REG_IDX_W];
    assign rspWord = rspData[PORT_W-1:0];

    // Memory responses drain at once, register responses wait for the core
    assign regWb = rspAck && rspIsReg;
    assign rspReq = rspIsReg ? wbReq : 1'b1;
    assign staleReq = wbReq && !regWb;

    assign wbAck = regWb || staleAck;
    assign wbDestReg = regWb ? rspDest : staleDest;
    assign wbData = regWb ? rspWord[DATA_W-1:0] : staleData;

    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            loadWord <= '0;
        end else if (rspAck && rspReq) begin
            loadWord <= rspWord;
        end
    end

    // Stale load alignment
    assign slotWord = loadWord[staleAddr[SLOT_BITS-1:0]];
    assign byteLane = (BYTES_PER_WORD > 1) ? staleAddr[SLOT_BITS] : 1'b0;
    assign slotByte = slotWord[8*byteLane +: 8];

    always_comb begin
        case (ioCtrlPkg::accessSize'(staleOp[1:0]))
            ioCtrlPkg::SZ_BYTE:  staleData = DATA_W'(slotByte);
            ioCtrlPkg::SZ_SBYTE: staleData = DATA_W'($signed(slotByte));
            default:             staleData = slotWord;
        endcase
    end

endmodule

// ==== rtl/ioCommandController.sv ====
// IO command controller top level
`timescale 1ns/1ns

module ioCommandController #(
    parameter int PORT_BYTES = 4,
    parameter int DATA_W = 16
) (
    input  logic                            sys_clk,
    input  logic                            rstN,

    input  logic                            cmdAck,
    output logic                            cmdReq,
    input  ioCtrlPkg::ioMinorOp             minorOp,
    input  logic [DATA_W-1:0]               addrOffset,
    input  logic [DATA_W-1:0]               cmdData,
    input  logic [ioCtrlPkg::REG_IDX_W-1:0] destReg,

    output logic                            wbAck,
    input  logic                            wbReq,
    output logic [ioCtrlPkg::REG_IDX_W-1:0] wbDestReg,
    output logic [DATA_W-1:0]               wbData,

    output logic                            ioCmdAck,
    input  logic                            ioCmdReq,
    output logic                            ioRespRequested,
    output logic [ioCtrlPkg::REG_IDX_W-1:0] ioDestRegOut,
    output logic [PORT_BYTES*8-1:0]         ioDataOut,

    input  logic                            ioRspAck,
    output logic                            ioRspReq,
    input  logic                            ioRegRespFlag,
    input  logic                            ioMemRespFlag,
    input  logic [ioCtrlPkg::REG_IDX_W-1:0] ioDestRegIn,
    input  logic [PORT_BYTES*8-1:0]         ioDataIn
);

    localparam int PORT_W = PORT_BYTES * 8;
    localparam int SLOTS = PORT_W / DATA_W;
    localparam int SLOT_BITS = (SLOTS <= 2) ? 1 : $clog2(SLOTS);
    localparam int ADDR_W = SLOT_BITS + 1;
    // Flag, destination register and port word
    localparam int ENTRY_W = 1 + ioCtrlPkg::REG_IDX_W + PORT_W;

    logic packAck;
    logic packReq;
    logic [ENTRY_W-1:0] packData;
    logic [ENTRY_W-1:0] cmdQueueData;
    logic staleAck;
    logic staleReq;
    ioCtrlPkg::ioMinorOp staleOp;
    logic [ADDR_W-1:0] staleAddr;
    logic [ioCtrlPkg::REG_IDX_W-1:0] staleDest;
    logic rspInAck;
    logic rspOutAck;
    logic rspOutReq;
    logic [ENTRY_W-1:0] rspOutData;

    ioCmdIf #(.PORT_BYTES(PORT_BYTES), .DATA_W(DATA_W)) decoded ();

    cmdDecode #(.PORT_BYTES(PORT_BYTES), .DATA_W(DATA_W)) decodeStage (
        .sys_clk   (sys_clk),
        .rstN      (rstN),
        .cmdAck    (cmdAck),
        .minorOp   (minorOp),
        .addrOffset(addrOffset),
        .cmdData   (cmdData),
        .destReg   (destReg),
        .cmdReq    (cmdReq),
        .down      (decoded.sender)
    );

    storePacker #(.PORT_BYTES(PORT_BYTES), .DATA_W(DATA_W)) packer (
        .sys_clk  (sys_clk),
        .rstN     (rstN),
        .up       (decoded.receiver),
        .fifoAck  (packAck),
        .fifoData (packData),
        .fifoReq  (packReq),
        .staleAck (staleAck),
        .staleOp  (staleOp),
        .staleAddr(staleAddr),
        .staleDest(staleDest),
        .staleReq (staleReq)
    );

    syncFifo #(.WIDTH(ENTRY_W)) cmdQueue (
        .sys_clk(sys_clk),
        .rstN   (rstN),
        .inAck  (packAck),
        .inData (packData),
        .inReq  (packReq),
        .outAck (ioCmdAck),
        .outData(cmdQueueData),
        .outReq (ioCmdReq)
    );

    assign ioRespRequested = cmdQueueData[ENTRY_W-1];
    assign ioDestRegOut = cmdQueueData[PORT_W +: ioCtrlPkg::REG_IDX_W];
    assign ioDataOut = cmdQueueData[PORT_W-1:0];

    // Responses with neither flag set are dropped
    assign rspInAck = ioRspAck && (ioRegRespFlag || ioMemRespFlag);

    syncFifo #(.WIDTH(ENTRY_W)) rspQueue (
        .sys_clk(sys_clk),
        .rstN   (rstN),
        .inAck  (rspInAck),
        .inData ({ioRegRespFlag, ioDestRegIn, ioDataIn}),
        .inReq  (ioRspReq),
        .outAck (rspOutAck),
        .outData(rspOutData),
        .outReq (rspOutReq)
    );

    writebackStage #(.PORT_BYTES(PORT_BYTES), .DATA_W(DATA_W)) writeback (
        .sys_clk  (sys_clk),
        .rstN     (rstN),
        .rspAck   (rspOutAck),
        .rspData  (rspOutData),
        .rspReq   (rspOutReq),
        .staleAck (staleAck),
        .staleOp  (staleOp),
        .staleAddr(staleAddr),
        .staleDest(staleDest),
        .staleReq (staleReq),
        .wbAck    (wbAck),
        .wbReq    (wbReq),
        .wbDestReg(wbDestReg),
        .wbData   (wbData)
    );

endmodule

// ==== dv/tbIoCommandController.sv ====
// IO command controller testbench
`timescale 1ns/1ns

module tbIoCommandController;

    localparam int PORT_BYTES = 4;
    localparam int DATA_W = 16;
    localparam int PORT_W = PORT_BYTES * 8;
    localparam int SLOTS = PORT_W / DATA_W;
    localparam int SLOT_BITS = (SLOTS <= 2) ? 1 : $clog2(SLOTS);
    localparam int ADDR_W = SLOT_BITS + 1;
    localparam int REG_W = ioCtrlPkg::REG_IDX_W;
    localparam int CMD_W = 1 + REG_W + PORT_W;
    localparam int RESET_CYCLES = 10;
    // FIFO entries plus the packer and decode registers
    localparam int FILL_STORES = ioCtrlPkg::FIFO_DEPTH + 2;
    // Rough length of each test plus margin
    localparam int MAX_CYCLES = RESET_CYCLES + 20 + 40 + 40 + 50 + 100 + 40 + 200;

    logic sys_clk;
    logic rstN;
    logic cmdAck;
    logic cmdReq;
    ioCtrlPkg::ioMinorOp minorOp;
    logic [DATA_W-1:0] addrOffset;
    logic [DATA_W-1:0] cmdData;
    logic [REG_W-1:0] destReg;
    logic wbAck;
    logic wbReq;
    logic [REG_W-1:0] wbDestReg;
    logic [DATA_W-1:0] wbData;
    logic ioCmdAck;
    logic ioCmdReq;
    logic ioRespRequested;
    logic [REG_W-1:0] ioDestRegOut;
    logic [PORT_W-1:0] ioDataOut;
    logic ioRspAck;
    logic ioRspReq;
    logic ioRegRespFlag;
    logic ioMemRespFlag;
    logic [REG_W-1:0] ioDestRegIn;
    logic [PORT_W-1:0] ioDataIn;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic [31:0] rngState = 32'ha403_902a;
    // Reference copies of the store word and the load word
    logic [PORT_W-1:0] modelStore;
    logic [PORT_W-1:0] modelLoad;
    logic [REG_W+DATA_W-1:0] wbSeen [$];
    logic [CMD_W-1:0] cmdSeen [$];

    ioCommandController #(.PORT_BYTES(PORT_BYTES), .DATA_W(DATA_W)) i_ioCommandController (
        .sys_clk        (sys_clk),
        .rstN           (rstN),
        .cmdAck         (cmdAck),
        .cmdReq         (cmdReq),
        .minorOp        (minorOp),
        .addrOffset     (addrOffset),
        .cmdData        (cmdData),
        .destReg        (destReg),
        .wbAck          (wbAck),
        .wbReq          (wbReq),
        .wbDestReg      (wbDestReg),
        .wbData         (wbData),
        .ioCmdAck       (ioCmdAck),
        .ioCmdReq       (ioCmdReq),
        .ioRespRequested(ioRespRequested),
        .ioDestRegOut   (ioDestRegOut),
        .ioDataOut      (ioDataOut),
        .ioRspAck       (ioRspAck),
        .ioRspReq       (ioRspReq),
        .ioRegRespFlag  (ioRegRespFlag),
        .ioMemRespFlag  (ioMemRespFlag),
        .ioDestRegIn    (ioDestRegIn),
        .ioDataIn       (ioDataIn)
    );

    always #50 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // A handshake seen here completes on the next rising edge
    always @(negedge sys_clk) begin
        if (rstN && wbAck && wbReq) begin
            wbSeen.push_back({wbDestReg, wbData});
        end
        if (rstN && ioCmdAck && ioCmdReq) begin
            cmdSeen.push_back({ioRespRequested, ioDestRegOut, ioDataOut});
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic nextRandom(output logic [31:0] r);
        rngState = xorshift32(rngState);
        r = rngState;
    endtask

    // Store merge by the slot and byte lane rules
    function automatic logic [PORT_W-1:0] mergeStore(input logic [PORT_W-1:0] word,
            input ioCtrlPkg::ioMinorOp op, input logic [ADDR_W-1:0] addr,
            input logic [DATA_W-1:0] data);
        int base;
        base = DATA_W * int'(addr[SLOT_BITS-1:0]);
        if (ioCtrlPkg::accessSize'(op[1:0]) == ioCtrlPkg::SZ_WORD) begin
            word[base +: DATA_W] = data;
        end else begin
            if (DATA_W > 8) begin
                base = base + 8 * int'(addr[SLOT_BITS]);
            end
            word[base +: 8] = data[7:0];
        end
        return word;
    endfunction

    function automatic logic [DATA_W-1:0] alignLoad(input logic [PORT_W-1:0] word,
            input ioCtrlPkg::ioMinorOp op, input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] slotWord;
        logic [7:0] b;
        int lane;
        slotWord = word[DATA_W * int'(addr[SLOT_BITS-1:0]) +: DATA_W];
        lane = (DATA_W > 8) ? int'(addr[SLOT_BITS]) : 0;
        b = slotWord[8 * lane +: 8];
        case (ioCtrlPkg::accessSize'(op[1:0]))
            ioCtrlPkg::SZ_BYTE:  return DATA_W'(b);
            ioCtrlPkg::SZ_SBYTE: return DATA_W'($signed(b));
            default:             return slotWord;
        endcase
    endfunction

    task automatic waitCycles(input int n);
        repeat (n) @(posedge sys_clk);
    endtask

    task automatic driveCommand(input ioCtrlPkg::ioMinorOp op, input logic [ADDR_W-1:0] addr,
            input logic [DATA_W-1:0] data, input logic [REG_W-1:0] dest);
        @(posedge sys_clk);
        cmdAck <= 1'b1;
        minorOp <= op;
        addrOffset <= DATA_W'(addr);
        cmdData <= data;
        destReg <= dest;
        @(negedge sys_clk);
        while (!cmdReq) begin
            @(negedge sys_clk);
        end
        @(posedge sys_clk);
        cmdAck <= 1'b0;
    endtask

    task automatic driveResponse(input logic isReg, input logic isMem,
            input logic [REG_W-1:0] dest, input logic [PORT_W-1:0] word);
        @(posedge sys_clk);
        ioRspAck <= 1'b1;
        ioRegRespFlag <= isReg;
        ioMemRespFlag <= isMem;
        ioDestRegIn <= dest;
        ioDataIn <= word;
        @(negedge sys_clk);
        while (!ioRspReq) begin
            @(negedge sys_clk);
        end
        @(posedge sys_clk);
        ioRspAck <= 1'b0;
    endtask

    task automatic compareWb(input logic [REG_W-1:0] expDest, input logic [DATA_W-1:0] expData);
        logic [REG_W+DATA_W-1:0] got;
        while (wbSeen.size() == 0) begin
            @(posedge sys_clk);
        end
        got = wbSeen.pop_front();
        checks++;
        if (got !== {expDest, expData}) begin
            errors++;
            $display("ERR %0t: writeback dest %0d data %h, expected dest %0d data %h",
                $time, got[DATA_W +: REG_W], got[DATA_W-1:0], expDest, expData);
        end
    endtask

    task automatic compareIoCmd(input logic expResp, input logic [REG_W-1:0] expDest,
            input logic [PORT_W-1:0] expWord);
        logic [CMD_W-1:0] got;
        while (cmdSeen.size() == 0) begin
            @(posedge sys_clk);
        end
        got = cmdSeen.pop_front();
        checks++;
        if (got !== {expResp, expDest, expWord}) begin
            errors++;
            $display("ERR %0t: port command resp %b dest %0d word %h, expected %b %0d %h",
                $time, got[CMD_W-1], got[PORT_W +: REG_W], got[PORT_W-1:0],
                expResp, expDest, expWord);
        end
    endtask

    task automatic compareFlag(input string what, input logic got, input logic expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, expected);
        end
    endtask

    task automatic expectIdle(input string what);
        checks++;
        if (wbSeen.size() != 0 || cmdSeen.size() != 0) begin
            errors++;
            $display("ERR %0t: %s: %0d writebacks and %0d port commands, expected none",
                $time, what, wbSeen.size(), cmdSeen.size());
        end
    endtask

    task automatic testReset();
        @(negedge sys_clk);
        compareFlag("ioCmdAck after reset", ioCmdAck, 1'b0);
        compareFlag("wbAck after reset", wbAck, 1'b0);
        compareFlag("cmdReq after reset", cmdReq, 1'b1);
        compareFlag("ioRspReq after reset", ioRspReq, 1'b1);
        driveCommand(ioCtrlPkg::LD_STALE_WORD, '0, '0, 4'd3);
        compareWb(4'd3, alignLoad(modelLoad, ioCtrlPkg::LD_STALE_WORD, '0));
    endtask

    task automatic testStoreMerge();
        logic [31:0] r;
        nextRandom(r);
        modelStore = mergeStore(modelStore, ioCtrlPkg::ST_WORD, 2'b01, r[DATA_W-1:0]);
        driveCommand(ioCtrlPkg::ST_WORD, 2'b01, r[DATA_W-1:0], 4'd1);
        nextRandom(r);
        modelStore = mergeStore(modelStore, ioCtrlPkg::ST_BYTE, 2'b10, r[DATA_W-1:0]);
        driveCommand(ioCtrlPkg::ST_BYTE, 2'b10, r[DATA_W-1:0], 4'd2);
        waitCycles(4);
        expectIdle("stores without send");
        nextRandom(r);
        modelStore = mergeStore(modelStore, ioCtrlPkg::ST_BYTE_SEND, 2'b00, r[DATA_W-1:0]);
        driveCommand(ioCtrlPkg::ST_BYTE_SEND, 2'b00, r[DATA_W-1:0], 4'd5);
        compareIoCmd(1'b0, 4'd5, modelStore);
        waitCycles(5);
        expectIdle("after the send-store");
    endtask

    task automatic testFetchLoad();
        logic [31:0] r;
        driveCommand(ioCtrlPkg::LD_WORD, 2'b00, '0, 4'd9);
        compareIoCmd(1'b1, 4'd9, modelStore);
        nextRandom(r);
        modelLoad = r[PORT_W-1:0];
        driveResponse(1'b1, 1'b0, 4'd9, r[PORT_W-1:0]);
        compareWb(4'd9, r[DATA_W-1:0]);
    endtask

    task automatic testMemResponse();
        logic [31:0] r;
        nextRandom(r);
        // Top bytes of the upper slot get bit 7 set for the extension checks
        modelLoad = r[PORT_W-1:0] | 32'h8080_0000;
        driveResponse(1'b0, 1'b1, 4'd2, modelLoad);
        waitCycles(6);
        expectIdle("memory response");
        driveCommand(ioCtrlPkg::LD_STALE_BYTE, 2'b11, '0, 4'd1);
        compareWb(4'd1, alignLoad(modelLoad, ioCtrlPkg::LD_STALE_BYTE, 2'b11));
        driveCommand(ioCtrlPkg::LD_STALE_SBYTE, 2'b01, '0, 4'd2);
        compareWb(4'd2, alignLoad(modelLoad, ioCtrlPkg::LD_STALE_SBYTE, 2'b01));
        driveCommand(ioCtrlPkg::LD_STALE_WORD, 2'b00, '0, 4'd3);
        compareWb(4'd3, alignLoad(modelLoad, ioCtrlPkg::LD_STALE_WORD, 2'b00));
    endtask

    task automatic testCmdBackPressure();
        logic [CMD_W-1:0] expected [$];
        logic [CMD_W-1:0] e;
        logic [31:0] r;
        @(posedge sys_clk);
        ioCmdReq <= 1'b0;
        for (int i = 0; i < FILL_STORES; i++) begin
            nextRandom(r);
            modelStore = mergeStore(modelStore, ioCtrlPkg::ST_WORD_SEND, ADDR_W'(i),
                r[DATA_W-1:0]);
            expected.push_back({1'b0, REG_W'(i), modelStore});
            driveCommand(ioCtrlPkg::ST_WORD_SEND, ADDR_W'(i), r[DATA_W-1:0], REG_W'(i));
        end
        waitCycles(3);
        @(negedge sys_clk);
        compareFlag("cmdReq with the port stalled", cmdReq, 1'b0);
        expectIdle("port stalled");
        @(posedge sys_clk);
        ioCmdReq <= 1'b1;
        while (expected.size() != 0) begin
            e = expected.pop_front();
            compareIoCmd(e[CMD_W-1], e[PORT_W +: REG_W], e[PORT_W-1:0]);
        end
    endtask

    task automatic testWbPriority();
        logic [31:0] r;
        @(posedge sys_clk);
        wbReq <= 1'b0;
        nextRandom(r);
        driveResponse(1'b1, 1'b0, 4'd7, r[PORT_W-1:0]);
        driveCommand(ioCtrlPkg::LD_STALE_WORD, 2'b01, '0, 4'd4);
        waitCycles(4);
        @(negedge sys_clk);
        compareFlag("wbAck while the core stalls", wbAck, 1'b1);
        expectIdle("core stalled");
        @(posedge sys_clk);
        wbReq <= 1'b1;
        // Register response goes first and refreshes the load word
        compareWb(4'd7, r[DATA_W-1:0]);
        modelLoad = r[PORT_W-1:0];
        compareWb(4'd4, alignLoad(modelLoad, ioCtrlPkg::LD_STALE_WORD, 2'b01));
    endtask

    initial begin
        sys_clk = 1'b0;
        rstN = 1'b0;
        cmdAck = 1'b0;
        minorOp = ioCtrlPkg::LD_STALE_BYTE;
        addrOffset = '0;
        cmdData = '0;
        destReg = '0;
        wbReq = 1'b1;
        ioCmdReq = 1'b1;
        ioRspAck = 1'b0;
        ioRegRespFlag = 1'b0;
        ioMemRespFlag = 1'b0;
        ioDestRegIn = '0;
        ioDataIn = '0;
        modelStore = '0;
        modelLoad = '0;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        rstN <= 1'b1;

        testReset();
        testStoreMerge();
        testFetchLoad();
        testMemResponse();
        testCmdBackPressure();
        testWbPriority();
        waitCycles(5);
        expectIdle("end of run");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/ioCtrlPkg.sv
rtl/ioCmdIf.sv
rtl/cmdDecode.sv
rtl/storePacker.sv
rtl/syncFifo.sv
rtl/writebackStage.sv
rtl/ioCommandController.sv
dv/tbIoCommandController.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the IO command controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    --top-module tbIoCommandController -f vlog.f -o simIoCtrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simIoCtrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0
